//--- Makefile
# Verilator build and run of the DCCM SRAM export testbench

TOP := tb_dccm_sram_export
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f build.f
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- build.f
+incdir+include
logic/sram_export_pkg.sv
logic/dccm_req_if.sv
logic/dccm_flip_mask_gen.sv
logic/dccm_inject_stage.sv
logic/dccm_bank_array.sv
logic/dccm_sram_export.sv
sim/dccm_sram_export_properties.sv
sim/tb_dccm_sram_export.sv

//--- include/sram_export_macros.svh
/*
 * DCCM memory model sizing
 * Bank geometry, stored word layout and the LFSR constants used by the
 * write-side error injector
 */

`ifndef SRAM_EXPORT_MACROS_SVH
`define SRAM_EXPORT_MACROS_SVH

// Bank geometry, 64 words per bank
`define DCCM_NUM_BANKS    2
`define DCCM_INDEX_BITS   6

// Stored word is ECC over data
`define DCCM_DATA_WIDTH   32
`define DCCM_ECC_WIDTH    7
`define DCCM_WORD_WIDTH   39

// Galois LFSR that picks corrupted writes and bit positions
`define FLIP_LFSR_SEED    16'hACE1
`define FLIP_LFSR_TAPS    16'hB400

`endif

//--- logic/dccm_bank_array.sv
/*
 * DCCM bank array
 * Second pipeline stage. One 64 x 39 SRAM per bank, written from the
 * registered request, with registered read data and ECC per bank
 */

`timescale 1ns/1ns

`include "sram_export_macros.svh"

module dccm_bank_array import sram_export_pkg::*; (
    input  logic                                             el2_mem_export,
    input  logic                                             rst,
    dccm_req_if.sink                                         req,
    output logic [`DCCM_NUM_BANKS-1:0][`DCCM_DATA_WIDTH-1:0] dccm_bank_dout,
    output logic [`DCCM_NUM_BANKS-1:0][`DCCM_ECC_WIDTH-1:0]  dccm_bank_ecc
);

    localparam int DEPTH = 1 << `DCCM_INDEX_BITS;

    for (genvar b = 0; b < `DCCM_NUM_BANKS; b++) begin : g_bank

        dccm_word_t                   mem [DEPTH];
        logic [`DCCM_DATA_WIDTH-1:0] dout_q;
        logic [`DCCM_ECC_WIDTH-1:0]  ecc_q;

        ////////////////////
        // Write port
        always_ff @(posedge el2_mem_export) begin
            if (req.clken[b] && req.wren[b]) begin
                mem[req.addr[b]] <= req.wdata[b];
            end
        end

        ////////////////////
        // Read port
        // Holds its value until the next read of this bank
        always_ff @(posedge el2_mem_export) begin
            if (rst) begin
                dout_q <= '0;
                ecc_q  <= '0;
            end else if (req.clken[b] && !req.wren[b]) begin
                dout_q <= mem[req.addr[b]].fields.data;
                ecc_q  <= mem[req.addr[b]].fields.ecc;
            end
        end

        assign dccm_bank_dout[b] = dout_q;
        assign dccm_bank_ecc[b]  = ecc_q;

    end

endmodule

//--- logic/dccm_flip_mask_gen.sv
/*
 * DCCM bit-flip mask generator
 * A 16-bit Galois LFSR steps on every write while injection is on. Its low
 * bits pick the corrupted banks, its upper byte the flipped bit position
 */

`timescale 1ns/1ns

`include "sram_export_macros.svh"

module dccm_flip_mask_gen (
    input  logic                        el2_mem_export,
    input  logic                        rst,
    input  logic                        write_seen,
    input  logic                        single_bit_error,
    input  logic                        double_bit_error,
    output logic [`DCCM_NUM_BANKS-1:0]  flip,
    output logic [`DCCM_WORD_WIDTH-1:0] mask
);

    logic        inject_on;
    logic [15:0] lfsr;
    logic [15:0] lfsr_next;
    logic [7:0]  first_pos;
    logic [7:0]  second_pos;

    assign inject_on = single_bit_error | double_bit_error;

    // Shift right, fold taps back in when bit 0 leaves
    assign lfsr_next = lfsr[0] ? ((lfsr >> 1) ^ `FLIP_LFSR_TAPS) : (lfsr >> 1);

    always_ff @(posedge el2_mem_export) begin
        if (rst) begin
            lfsr <= `FLIP_LFSR_SEED;
        end else if (inject_on && write_seen) begin
            lfsr <= lfsr_next;
        end
    end

    ////////////////////
    // Mask from current state
    assign flip = inject_on ? lfsr[`DCCM_NUM_BANKS-1:0] : '0;

    assign first_pos  = lfsr[15:8] % 8'(`DCCM_WORD_WIDTH);
    assign second_pos = (first_pos == 8'(`DCCM_WORD_WIDTH - 1)) ? 8'd0 : first_pos + 8'd1;

    // Double mode adds the neighbour, wrapping at the top bit
    assign mask = (`DCCM_WORD_WIDTH'(1) << first_pos) |
                  (double_bit_error ? (`DCCM_WORD_WIDTH'(1) << second_pos) : '0);

endmodule

//--- logic/dccm_inject_stage.sv
/*
 * DCCM inject stage
 * First pipeline stage. Packs each bank's write data and ECC into one word,
 * flips the selected bits of corrupted writes and registers the request
 */

`timescale 1ns/1ns

`include "sram_export_macros.svh"

module dccm_inject_stage import sram_export_pkg::*; (
    input  logic                                             el2_mem_export,
    input  logic                                             rst,
    input  logic                                             single_bit_error,
    input  logic                                             double_bit_error,
    input  logic [`DCCM_NUM_BANKS-1:0]                       dccm_clken,
    input  logic [`DCCM_NUM_BANKS-1:0]                       dccm_wren_bank,
    input  logic [`DCCM_NUM_BANKS-1:0][`DCCM_INDEX_BITS-1:0] dccm_addr_bank,
    input  logic [`DCCM_NUM_BANKS-1:0][`DCCM_DATA_WIDTH-1:0] dccm_wr_data_bank,
    input  logic [`DCCM_NUM_BANKS-1:0][`DCCM_ECC_WIDTH-1:0]  dccm_wr_ecc_bank,
    dccm_req_if.source                                       req
);

    logic       [`DCCM_NUM_BANKS-1:0]  bank_write;
    logic       [`DCCM_NUM_BANKS-1:0]  flip;
    logic       [`DCCM_WORD_WIDTH-1:0] mask;
    dccm_word_t [`DCCM_NUM_BANKS-1:0]  clean_word;
    dccm_word_t [`DCCM_NUM_BANKS-1:0]  wr_word;

    assign bank_write = dccm_clken & dccm_wren_bank;

    dccm_flip_mask_gen i_flip_mask_gen (
        .el2_mem_export   (el2_mem_export),
        .rst              (rst),
        .write_seen       (|bank_write),
        .single_bit_error (single_bit_error),
        .double_bit_error (double_bit_error),
        .flip             (flip),
        .mask             (mask)
    );

    always_comb begin
        for (int b = 0; b < `DCCM_NUM_BANKS; b++) begin
            clean_word[b].fields.ecc  = dccm_wr_ecc_bank[b];
            clean_word[b].fields.data = dccm_wr_data_bank[b];
        end
    end

    // Same mask for every corrupted bank this cycle
    always_comb begin
        for (int b = 0; b < `DCCM_NUM_BANKS; b++) begin
            wr_word[b].raw = clean_word[b].raw ^ ((flip[b] && bank_write[b]) ? mask : '0);
        end
    end

    ////////////////////
    // Request register
    always_ff @(posedge el2_mem_export) begin
        if (rst) begin
            req.clken <= '0;
            req.wren  <= '0;
        end else begin
            req.clken <= dccm_clken;
            req.wren  <= dccm_wren_bank;
        end
    end

    always_ff @(posedge el2_mem_export) begin
        req.addr  <= dccm_addr_bank;
        req.wdata <= wr_word;
    end

endmodule

//--- logic/dccm_req_if.sv
/*
 * DCCM bank request
 * One registered request per bank, passed from the inject stage to the
 * bank array. clken with wren writes, clken alone reads
 */

`timescale 1ns/1ns

`include "sram_export_macros.svh"

interface dccm_req_if import sram_export_pkg::*; ();

    logic       [`DCCM_NUM_BANKS-1:0]                       clken;
    logic       [`DCCM_NUM_BANKS-1:0]                       wren;
    logic       [`DCCM_NUM_BANKS-1:0][`DCCM_INDEX_BITS-1:0] addr;
    dccm_word_t [`DCCM_NUM_BANKS-1:0]                       wdata;

    modport source (
        output clken, wren, addr, wdata
    );

    modport sink (
        input clken, wren, addr, wdata
    );

endinterface

//--- logic/dccm_sram_export.sv
/*
 * DCCM SRAM export model
 * Banked 39-bit data-side memory with write-side single or double bit
 * error injection. Read data returns two cycles after the request
 */

`timescale 1ns/1ns

`include "sram_export_macros.svh"

module dccm_sram_export (
    input  logic                                             el2_mem_export,
    input  logic                                             rst,

    // Injection modes, double wins when both are set
    input  logic                                             single_bit_error,
    input  logic                                             double_bit_error,

    input  logic [`DCCM_NUM_BANKS-1:0]                       dccm_clken,
    input  logic [`DCCM_NUM_BANKS-1:0]                       dccm_wren_bank,
    input  logic [`DCCM_NUM_BANKS-1:0][`DCCM_INDEX_BITS-1:0] dccm_addr_bank,
    input  logic [`DCCM_NUM_BANKS-1:0][`DCCM_DATA_WIDTH-1:0] dccm_wr_data_bank,
    input  logic [`DCCM_NUM_BANKS-1:0][`DCCM_ECC_WIDTH-1:0]  dccm_wr_ecc_bank,
    output logic [`DCCM_NUM_BANKS-1:0][`DCCM_DATA_WIDTH-1:0] dccm_bank_dout,
    output logic [`DCCM_NUM_BANKS-1:0][`DCCM_ECC_WIDTH-1:0]  dccm_bank_ecc
);

    dccm_req_if i_req ();

    ////////////////////
    // Stage 1, injection
    dccm_inject_stage i_inject_stage (
        .el2_mem_export    (el2_mem_export),
        .rst               (rst),
        .single_bit_error  (single_bit_error),
        .double_bit_error  (double_bit_error),
        .dccm_clken        (dccm_clken),
        .dccm_wren_bank    (dccm_wren_bank),
        .dccm_addr_bank    (dccm_addr_bank),
        .dccm_wr_data_bank (dccm_wr_data_bank),
        .dccm_wr_ecc_bank  (dccm_wr_ecc_bank),
        .req               (i_req.source)
    );

    ////////////////////
    // Stage 2, banks
    dccm_bank_array i_bank_array (
        .el2_mem_export (el2_mem_export),
        .rst            (rst),
        .req            (i_req.sink),
        .dccm_bank_dout (dccm_bank_dout),
        .dccm_bank_ecc  (dccm_bank_ecc)
    );

endmodule

//--- logic/sram_export_pkg.sv
/*
 * DCCM memory model types
 * Stored SRAM word, seen either as ECC and data fields or as one raw vector
 */

`include "sram_export_macros.svh"

package sram_export_pkg;

    typedef struct packed {
        logic [`DCCM_ECC_WIDTH-1:0]  ecc;
        logic [`DCCM_DATA_WIDTH-1:0] data;
    } dccm_word_fields_t;

    // Fields for the ports, raw for the bit-flip mask
    typedef union packed {
        dccm_word_fields_t            fields;
        logic [`DCCM_WORD_WIDTH-1:0] raw;
    } dccm_word_t;

endpackage

//--- sim/dccm_sram_export_properties.sv
/*
 * Inject stage checks
 * LFSR state, flip mask weight and the request register after reset
 */

`timescale 1ns/1ns

`include "sram_export_macros.svh"

module dccm_sram_export_properties (
    input logic                        el2_mem_export,
    input logic                        rst,
    input logic                        double_bit_error,
    input logic [15:0]                 lfsr,
    input logic [`DCCM_WORD_WIDTH-1:0] mask,
    input logic [`DCCM_NUM_BANKS-1:0]  req_clken
);

    // An all-zero state would lock the LFSR
    lfsr_nonzero: assert property (@(posedge el2_mem_export) disable iff (rst)
        lfsr != 16'h0000)
        else $error("LFSR reached the all-zero state");

    mask_weight: assert property (@(posedge el2_mem_export) disable iff (rst)
        $countones(mask) == (double_bit_error ? 2 : 1))
        else $error("flip mask weight does not match the injection mode");

    clken_after_reset: assert property (@(posedge el2_mem_export)
        rst |=> req_clken == '0)
        else $error("registered clken not cleared in the cycle after reset");

endmodule

bind dccm_inject_stage dccm_sram_export_properties i_properties (
    .el2_mem_export   (el2_mem_export),
    .rst              (rst),
    .double_bit_error (double_bit_error),
    .lfsr             (i_flip_mask_gen.lfsr),
    .mask             (mask),
    .req_clken        (req.clken)
);

//--- sim/tb_dccm_sram_export.sv
/*
 * Testbench for the DCCM SRAM export model
 * Writes and reads both banks under each injection mode and checks the
 * read data against a shadow memory and a model of the flip LFSR
 */

`timescale 1ns/1ns

`include "sram_export_macros.svh"

module tb_dccm_sram_export import sram_export_pkg::*; ();

    localparam int NB    = `DCCM_NUM_BANKS;
    localparam int IB    = `DCCM_INDEX_BITS;
    localparam int DEPTH = 1 << `DCCM_INDEX_BITS;

    logic                                             el2_mem_export;
    logic                                             rst;
    logic                                             single_bit_error;
    logic                                             double_bit_error;
    logic [`DCCM_NUM_BANKS-1:0]                       dccm_clken;
    logic [`DCCM_NUM_BANKS-1:0]                       dccm_wren_bank;
    logic [`DCCM_NUM_BANKS-1:0][`DCCM_INDEX_BITS-1:0] dccm_addr_bank;
    logic [`DCCM_NUM_BANKS-1:0][`DCCM_DATA_WIDTH-1:0] dccm_wr_data_bank;
    logic [`DCCM_NUM_BANKS-1:0][`DCCM_ECC_WIDTH-1:0]  dccm_wr_ecc_bank;
    logic [`DCCM_NUM_BANKS-1:0][`DCCM_DATA_WIDTH-1:0] dccm_bank_dout;
    logic [`DCCM_NUM_BANKS-1:0][`DCCM_ECC_WIDTH-1:0]  dccm_bank_ecc;

    // Reference model state
    logic [15:0] model_lfsr;
    logic        mode_single;
    logic        mode_double;
    dccm_word_t  shadow_word  [NB][DEPTH];
    dccm_word_t  shadow_clean [NB][DEPTH];
    int          shadow_nflip [NB][DEPTH];

    // Expected reads delayed alongside the DUT pipeline
    logic       [NB-1:0]      rd_chk_d, p1_chk, p2_chk;
    dccm_word_t [NB-1:0]      rd_exp_d, p1_exp, p2_exp;
    dccm_word_t [NB-1:0]      rd_clean_d, p1_clean, p2_clean;
    logic       [NB-1:0][1:0] rd_nflip_d, p1_nflip, p2_nflip;
    string                    rd_name_d, p1_name, p2_name;

    dccm_sram_export i_dccm_sram_export (
        .el2_mem_export    (el2_mem_export),
        .rst               (rst),
        .single_bit_error  (single_bit_error),
        .double_bit_error  (double_bit_error),
        .dccm_clken        (dccm_clken),
        .dccm_wren_bank    (dccm_wren_bank),
        .dccm_addr_bank    (dccm_addr_bank),
        .dccm_wr_data_bank (dccm_wr_data_bank),
        .dccm_wr_ecc_bank  (dccm_wr_ecc_bank),
        .dccm_bank_dout    (dccm_bank_dout),
        .dccm_bank_ecc     (dccm_bank_ecc)
    );

    initial begin
        el2_mem_export = 1'b0;
        forever #2 el2_mem_export = ~el2_mem_export;
    end

    ////////////////////
    // Reference model
    function automatic logic [15:0] lfsr_advance(input logic [15:0] state);
        return {1'b0, state[15:1]} ^ (state[0] ? `FLIP_LFSR_TAPS : 16'h0000);
    endfunction

    // Word as stored after the corruption rule
    function automatic dccm_word_t corrupt_ref(input dccm_word_t clean, input logic [15:0] state,
                                               input int bank, input logic single,
                                               input logic dbl);
        dccm_word_t word;
        int         pos;
        word = clean;
        if ((single || dbl) && state[bank]) begin
            pos = int'(state[15:8]) % `DCCM_WORD_WIDTH;
            word.raw[pos] = ~word.raw[pos];
            if (dbl) begin
                pos = (pos + 1) % `DCCM_WORD_WIDTH;
                word.raw[pos] = ~word.raw[pos];
            end
        end
        return word;
    endfunction

    function automatic dccm_word_t random_word();
        dccm_word_t word;
        word.fields.data = $urandom;
        word.fields.ecc  = `DCCM_ECC_WIDTH'($urandom);
        return word;
    endfunction

    ////////////////////
    // Compare tasks
    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic compare_word(input string name, input dccm_word_t expected,
                                input dccm_word_t actual);
        if (actual !== expected) begin
            report_failure($sformatf("mismatch %s: expected %h actual %h",
                                     name, expected.raw, actual.raw));
        end
    endtask

    task automatic verify_flip_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            report_failure($sformatf("mismatch %s flipped bits: expected %0d actual %0d",
                                     name, expected, actual));
        end
    endtask

    task automatic expect_cleared(input string name, input logic [`DCCM_WORD_WIDTH-1:0] actual);
        if (actual !== '0) begin
            report_failure($sformatf("mismatch %s: expected %h actual %h", name,
                                     `DCCM_WORD_WIDTH'(0), actual));
        end
    endtask

    ////////////////////
    // Stimulus
    task automatic drive_cycle(input string name, input logic [NB-1:0] ce,
                               input logic [NB-1:0] we, input logic [NB-1:0][IB-1:0] addr,
                               input dccm_word_t [NB-1:0] clean);
        logic       [NB-1:0]      chk;
        dccm_word_t [NB-1:0]      exp_w;
        dccm_word_t [NB-1:0]      exp_c;
        logic       [NB-1:0][1:0] nfl;
        chk   = '0;
        exp_w = '0;
        exp_c = '0;
        nfl   = '0;
        for (int b = 0; b < NB; b++) begin
            if (ce[b] && we[b]) begin
                shadow_word[b][addr[b]]  = corrupt_ref(clean[b], model_lfsr, b,
                                                       mode_single, mode_double);
                shadow_clean[b][addr[b]] = clean[b];
                shadow_nflip[b][addr[b]] = ((mode_single || mode_double) && model_lfsr[b]) ?
                                           (mode_double ? 2 : 1) : 0;
            end else if (ce[b]) begin
                chk[b]   = 1'b1;
                exp_w[b] = shadow_word[b][addr[b]];
                exp_c[b] = shadow_clean[b][addr[b]];
                nfl[b]   = 2'(shadow_nflip[b][addr[b]]);
            end
        end
        if ((mode_single || mode_double) && (ce & we) != '0) begin
            model_lfsr = lfsr_advance(model_lfsr);
        end
        @(posedge el2_mem_export);
        single_bit_error <= mode_single;
        double_bit_error <= mode_double;
        dccm_clken       <= ce;
        dccm_wren_bank   <= we;
        dccm_addr_bank   <= addr;
        for (int b = 0; b < NB; b++) begin
            dccm_wr_data_bank[b] <= clean[b].fields.data;
            dccm_wr_ecc_bank[b]  <= clean[b].fields.ecc;
        end
        rd_chk_d   <= chk;
        rd_exp_d   <= exp_w;
        rd_clean_d <= exp_c;
        rd_nflip_d <= nfl;
        rd_name_d  <= name;
    endtask

    // Fill every address of each bank, then read all back to back
    task automatic fill_and_read(input string name, input logic single, input logic dbl);
        logic       [NB-1:0][IB-1:0] addr;
        dccm_word_t [NB-1:0]         words;
        mode_single = single;
        mode_double = dbl;
        for (int i = 0; i < DEPTH; i++) begin
            for (int b = 0; b < NB; b++) begin
                addr[b]  = IB'(i + 17 * b);
                words[b] = random_word();
            end
            drive_cycle(name, '1, '1, addr, words);
        end
        for (int i = 0; i < DEPTH; i++) begin
            for (int b = 0; b < NB; b++) begin
                addr[b] = IB'((2 * b + 5) * i + 3 * b);
            end
            drive_cycle(name, '1, '0, addr, words);
        end
    endtask

    task automatic write_then_read(input string name, input logic single, input logic dbl,
                                   input int count);
        logic       [NB-1:0][IB-1:0] addr;
        dccm_word_t [NB-1:0]         words;
        mode_single = single;
        mode_double = dbl;
        for (int k = 0; k < count; k++) begin
            for (int b = 0; b < NB; b++) begin
                addr[b]  = IB'($urandom);
                words[b] = random_word();
            end
            drive_cycle(name, '1, '1, addr, words);
            drive_cycle(name, '1, '0, addr, words);
        end
    endtask

    ////////////////////
    // Compare process
    always @(posedge el2_mem_export) begin
        p1_chk   <= rd_chk_d;
        p1_exp   <= rd_exp_d;
        p1_clean <= rd_clean_d;
        p1_nflip <= rd_nflip_d;
        p1_name  <= rd_name_d;
        p2_chk   <= p1_chk;
        p2_exp   <= p1_exp;
        p2_clean <= p1_clean;
        p2_nflip <= p1_nflip;
        p2_name  <= p1_name;
    end

    always @(negedge el2_mem_export) begin : compare_reads
        dccm_word_t actual;
        for (int b = 0; b < NB; b++) begin
            if (p2_chk[b] === 1'b1) begin
                actual.fields.data = dccm_bank_dout[b];
                actual.fields.ecc  = dccm_bank_ecc[b];
                verify_flip_count(p2_name, int'(p2_nflip[b]),
                                  $countones(actual.raw ^ p2_clean[b].raw));
                compare_word(p2_name, p2_exp[b], actual);
            end
        end
    end

    initial begin
        logic       [NB-1:0][IB-1:0] idle_addr;
        dccm_word_t [NB-1:0]         idle_words;
        int                          timeout;
        void'($urandom(61));
        rst               = 1'b1;
        single_bit_error  = 1'b0;
        double_bit_error  = 1'b0;
        dccm_clken        = '0;
        dccm_wren_bank    = '0;
        dccm_addr_bank    = '0;
        dccm_wr_data_bank = '0;
        dccm_wr_ecc_bank  = '0;
        rd_chk_d          = '0;
        rd_exp_d          = '0;
        rd_clean_d        = '0;
        rd_nflip_d        = '0;
        rd_name_d         = "";
        model_lfsr        = `FLIP_LFSR_SEED;
        mode_single       = 1'b0;
        mode_double       = 1'b0;
        idle_addr         = '0;
        idle_words        = '0;
        repeat (8) @(posedge el2_mem_export);
        rst <= 1'b0;
        @(negedge el2_mem_export);
        for (int b = 0; b < NB; b++) begin
            expect_cleared("reset_clear", {dccm_bank_ecc[b], dccm_bank_dout[b]});
        end
        fill_and_read("no_inject", 1'b0, 1'b0);
        fill_and_read("single_bit", 1'b1, 1'b0);
        fill_and_read("double_bit", 1'b0, 1'b1);
        fill_and_read("both_modes", 1'b1, 1'b1);
        write_then_read("write_read_clean", 1'b0, 1'b0, 16);
        write_then_read("write_read_single", 1'b1, 1'b0, 16);
        write_then_read("write_read_double", 1'b0, 1'b1, 16);
        // Idle until every read in flight has been compared
        mode_single = 1'b0;
        mode_double = 1'b0;
        timeout = 0;
        @(negedge el2_mem_export);
        while ((rd_chk_d | p1_chk | p2_chk) != '0 && timeout < 8) begin
            drive_cycle("drain", '0, '0, idle_addr, idle_words);
            @(negedge el2_mem_export);
            timeout++;
        end
        if ((rd_chk_d | p1_chk | p2_chk) != '0) begin
            report_failure("reads were still in flight when the drain timeout ran out");
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule
